//--- logic/nn_pkg.sv
// shared word types, fixed-point constants and stage states, imported by every nn module
`default_nettype none

package nn_pkg;

  // word geometry
  localparam int WORD_W = 16;
  // q8.8, so 8 fraction bits
  localparam int FRAC_BITS = 8;

  // features per sample, one bn coefficient set each
  localparam int FEATURE_COUNT = 8;

  // saturation bounds of a signed 16 bit word
  localparam int WORD_MAX = 32767;
  localparam int WORD_MIN = -32768;

  // packed bn coefficients, read at elaboration
  localparam string COEFF_FILE = "sim/bn_coeff.hex";

  // signed q8.8 feature or coefficient
  typedef logic signed [WORD_W-1:0] word_t;

  // signed intermediate product
  typedef logic signed [2*WORD_W-1:0] wide_t;

  // mean | inv_std | scale | offset, mean in the top word
  typedef logic [4*WORD_W-1:0] coeff_t;

  // feature index into the coefficient rom
  typedef logic [$clog2(FEATURE_COUNT)-1:0] feat_idx_t;

  // one-entry stage controller
  typedef enum logic {
    S_EMPTY = 1'b0,
    S_FULL  = 1'b1
  } stage_state_e;

endpackage

`default_nettype wire

//--- logic/coeff_rom.sv
// synchronous-read rom of packed bn coefficients, one entry per feature, filled from a hex file
`timescale 1ns/1ns
`default_nettype none

module coeff_rom import nn_pkg::*; (
  input  wire logic      clk_i,
  input  wire feat_idx_t addr_i,
  output coeff_t         data_o
);

  // one packed coefficient set per feature
  coeff_t rom_mem [0:FEATURE_COUNT-1];

  // contents fixed at elaboration
  // no run-time write port
  initial begin
    $readmemh(COEFF_FILE, rom_mem);
  end

  // registered read
  // caller presents the next index so data lines up with the next word
  always_ff @(posedge clk_i) begin
    data_o <= rom_mem[addr_i];
  end

endmodule

`default_nettype wire

//--- logic/bn_layer.sv
// batch normalization stage, a valid-ready stage that normalizes a serial feature stream
`timescale 1ns/1ns
`default_nettype none

module bn_layer import nn_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  reset_i,

  // upstream link
  input  wire logic  valid_i,
  output logic       ready_o,
  input  wire word_t data_i,

  // downstream link
  output logic       valid_o,
  input  wire logic  ready_i,
  output word_t      data_o
);

  // controller state
  stage_state_e state_r;
  stage_state_e state_n;

  // load strobe for the output register and the counter
  logic en;

  // feature counter, current and next
  feat_idx_t count_r;
  feat_idx_t count_n;

  // coefficients for the feature at count_r
  coeff_t coeff_lo;
  word_t  mean;
  word_t  inv_std;
  word_t  scale;
  word_t  offset;

  // datapath intermediates
  wide_t diff;
  wide_t prod1;
  wide_t t1;
  logic signed [$bits(wide_t)+WORD_W-1:0] prod2;
  logic signed [$bits(wide_t)+WORD_W-1:0] t2;
  logic signed [$bits(wide_t)+WORD_W-1:0] sum;
  word_t sat;

  // state register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= S_EMPTY;
    end else begin
      state_r <= state_n;
    end
  end

  // next state
  // full stays full when a new word replaces the drained one
  always_comb begin
    case (state_r)
      S_EMPTY: state_n = valid_i ? S_FULL : S_EMPTY;
      S_FULL:  state_n = (ready_i && !valid_i) ? S_EMPTY : S_FULL;
      default: state_n = S_EMPTY;
    endcase
  end

  // helpful consumer
  // take a word when empty or when the held one leaves this cycle
  assign ready_o = (state_r == S_EMPTY) || ready_i;
  assign valid_o = (state_r == S_FULL);
  assign en      = valid_i && ready_o;

  // wrapping feature counter
  // reset sits in the next value so the rom prefetches entry 0
  always_comb begin
    if (reset_i) begin
      count_n = '0;
    end else if (en) begin
      if (count_r == feat_idx_t'(FEATURE_COUNT - 1)) begin
        count_n = '0;
      end else begin
        count_n = count_r + 1'b1;
      end
    end else begin
      count_n = count_r;
    end
  end

  always_ff @(posedge clk_i) begin
    count_r <= count_n;
  end

  // rom looks up count_n, so its output matches count_r after the edge
  coeff_rom u_coeff_rom (
    .clk_i  (clk_i),
    .addr_i (count_n),
    .data_o (coeff_lo)
  );

  // unpack, mean on top
  assign mean    = coeff_lo[4*WORD_W-1 -: WORD_W];
  assign inv_std = coeff_lo[3*WORD_W-1 -: WORD_W];
  assign scale   = coeff_lo[2*WORD_W-1 -: WORD_W];
  assign offset  = coeff_lo[WORD_W-1   -: WORD_W];

  // centre, 17 significant bits
  assign diff  = data_i - mean;
  // 17 x 16 bits fits in 32
  assign prod1 = diff * inv_std;
  // back to q8.8 scaling
  assign t1    = prod1 >>> FRAC_BITS;

  // second multiply can reach 40 bits, kept full width
  assign prod2 = t1 * scale;
  assign t2    = prod2 >>> FRAC_BITS;
  assign sum   = t2 + offset;

  // clip to the word range
  always_comb begin
    if (sum > WORD_MAX) begin
      sat = word_t'(WORD_MAX);
    end else if (sum < WORD_MIN) begin
      sat = word_t'(WORD_MIN);
    end else begin
      sat = sum[WORD_W-1:0];
    end
  end

  // output register, loaded on every accepted word
  always_ff @(posedge clk_i) begin
    if (en) begin
      data_o <= sat;
    end
  end

endmodule

`default_nettype wire

//--- logic/relu_layer.sv
// rectifier stage, a valid-ready stage that clips negative words to zero
`timescale 1ns/1ns
`default_nettype none

module relu_layer import nn_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  reset_i,

  // upstream link
  input  wire logic  valid_i,
  output logic       ready_o,
  input  wire word_t data_i,

  // downstream link
  output logic       valid_o,
  input  wire logic  ready_i,
  output word_t      data_o
);

  stage_state_e state_r;
  stage_state_e state_n;
  logic         en;

  // one-entry controller
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= S_EMPTY;
    end else begin
      state_r <= state_n;
    end
  end

  always_comb begin
    case (state_r)
      S_EMPTY: state_n = valid_i ? S_FULL : S_EMPTY;
      S_FULL:  state_n = (ready_i && !valid_i) ? S_EMPTY : S_FULL;
      default: state_n = S_EMPTY;
    endcase
  end

  // accept and emit in the same cycle
  assign ready_o = (state_r == S_EMPTY) || ready_i;
  assign valid_o = (state_r == S_FULL);
  assign en      = valid_i && ready_o;

  // negatives become zero
  always_ff @(posedge clk_i) begin
    if (en) begin
      data_o <= (data_i < 0) ? word_t'(0) : data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/maxpool_layer.sv
// max pooling stage, emits the larger of each pair of consecutive words at half the input rate
`timescale 1ns/1ns
`default_nettype none

module maxpool_layer import nn_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  reset_i,

  // upstream link
  input  wire logic  valid_i,
  output logic       ready_o,
  input  wire word_t data_i,

  // downstream link
  output logic       valid_o,
  input  wire logic  ready_i,
  output word_t      data_o
);

  // pair phase, low while waiting for the even word
  logic  odd_r;
  // even word of the open pair
  word_t even_r;
  // pending output
  logic  out_valid_r;
  word_t out_r;
  // handshake on the input side
  logic  take;
  // pair maximum
  word_t pair_max;

  // even word goes to even_r, which is always free at even phase
  // odd word needs the output register empty or draining
  assign ready_o = !odd_r || !out_valid_r || ready_i;
  assign take    = valid_i && ready_o;

  // signed compare
  assign pair_max = (data_i > even_r) ? data_i : even_r;

  // control, phase and output valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      odd_r       <= 1'b0;
      out_valid_r <= 1'b0;
    end else begin
      if (take) begin
        odd_r <= !odd_r;
      end
      // closing a pair refills the output, even while it drains
      if (take && odd_r) begin
        out_valid_r <= 1'b1;
      end else if (ready_i) begin
        out_valid_r <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (take && !odd_r) begin
      even_r <= data_i;
    end
    if (take && odd_r) begin
      out_r <= pair_max;
    end
  end

  assign valid_o = out_valid_r;
  assign data_o  = out_r;

endmodule

`default_nettype wire

//--- logic/nn_top.sv
// inference back end top, chains batch norm, relu and max pooling over one valid-ready stream
`timescale 1ns/1ns
`default_nettype none

module nn_top import nn_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  reset_i,

  // feature stream in
  input  wire logic  valid_i,
  output logic       ready_o,
  input  wire word_t data_i,

  // pooled stream out
  output logic       valid_o,
  input  wire logic  ready_i,
  output word_t      data_o
);

  // bn to relu
  logic  bn_valid;
  logic  bn_ready;
  word_t bn_data;

  // relu to maxpool
  logic  relu_valid;
  logic  relu_ready;
  word_t relu_data;

  // per-feature normalization
  bn_layer u_bn_layer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (bn_valid),
    .ready_i (bn_ready),
    .data_o  (bn_data)
  );

  // clip below zero
  relu_layer u_relu_layer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (bn_valid),
    .ready_o (bn_ready),
    .data_i  (bn_data),
    .valid_o (relu_valid),
    .ready_i (relu_ready),
    .data_o  (relu_data)
  );

  // pairwise max, half rate
  // three stages deep from the odd input to valid_o
  maxpool_layer u_maxpool_layer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (relu_valid),
    .ready_o (relu_ready),
    .data_i  (relu_data),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

endmodule

`default_nettype wire

//--- sim/nn_tb.sv
// testbench for nn_top that drives random feature streams and checks them against a bn relu pool model
`timescale 1ns/1ns
`default_nettype none

module nn_tb import nn_pkg::*; ();

  localparam int CLK_HALF = 50;

  // words sent per test
  localparam int N_STREAM = 64;
  localparam int N_BACKP  = 96;
  localparam int N_NEG    = 32;
  localparam int N_SAT    = 32;
  localparam int N_PRE    = 5;
  localparam int N_POST   = 16;
  localparam int TOTAL_WORDS = N_STREAM + N_BACKP + N_NEG + N_SAT + N_PRE + N_POST;
  // 20 cycles per word is far above the worst random stall
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 500;

  // data kinds
  localparam int MODE_RAND = 0;
  localparam int MODE_NEG  = 1;
  localparam int MODE_SAT  = 2;

  // downstream ready patterns
  localparam int RDY_LOW    = 0;
  localparam int RDY_HIGH   = 1;
  localparam int RDY_RANDOM = 2;

  logic  clk_i;
  logic  reset_i;
  logic  valid_i;
  logic  ready_o;
  word_t data_i;
  logic  valid_o;
  logic  ready_i;
  word_t data_o;

  // reference state
  coeff_t ref_coeff [0:FEATURE_COUNT-1];
  int     ref_idx;
  bit     ref_odd;
  word_t  ref_even;
  word_t  exp_q [$];

  // separate random streams for data and gaps and for ready
  logic [31:0] stim_state;
  logic [31:0] rdy_state;
  int          rdy_mode;

  // bookkeeping
  int    test_id;
  string test_name;
  int    err_count;
  int    err_start;
  int    test_outs;
  int    total_outs;
  int    tests_run;
  int    max_seen;

  nn_top u_nn_top (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #CLK_HALF clk_i = ~clk_i;

  // same hex file the rom uses
  initial begin
    $readmemh(COEFF_FILE, ref_coeff);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // next stimulus word of the requested kind
  function automatic word_t pick_word(input int mode);
    logic [31:0] r;
    stim_state = xorshift32(stim_state);
    r = stim_state;
    case (mode)
      // roughly -64.0 to -96.0 which is well under every mean
      MODE_NEG: return word_t'(-16384 - int'(r[12:0]));
      MODE_SAT: return r[0] ? word_t'(WORD_MAX) : word_t'(WORD_MIN);
      // +-8.0
      default:  return word_t'($signed(r[11:0]));
    endcase
  endfunction

  function automatic void ref_restart();
    ref_idx = 0;
    ref_odd = 1'b0;
    exp_q.delete();
  endfunction

  // bn, relu and pair max on one accepted word
  // a finished pair queues its expected output
  function automatic void bn_relu_pool_ref(input word_t x);
    word_t  m;
    word_t  is;
    word_t  sc;
    word_t  ofs;
    longint t1;
    longint t2;
    longint y;
    m   = ref_coeff[ref_idx][63:48];
    is  = ref_coeff[ref_idx][47:32];
    sc  = ref_coeff[ref_idx][31:16];
    ofs = ref_coeff[ref_idx][15:0];
    // each multiply rescaled back to q8.8
    t1 = ((longint'(x) - longint'(m)) * longint'(is)) >>> FRAC_BITS;
    t2 = (t1 * longint'(sc)) >>> FRAC_BITS;
    y  = t2 + longint'(ofs);
    if (y > WORD_MAX) begin
      y = WORD_MAX;
    end else if (y < WORD_MIN) begin
      y = WORD_MIN;
    end
    // relu
    if (y < 0) begin
      y = 0;
    end
    if (!ref_odd) begin
      ref_even = word_t'(y);
    end else begin
      exp_q.push_back((word_t'(y) > ref_even) ? word_t'(y) : ref_even);
    end
    ref_odd = !ref_odd;
    ref_idx = (ref_idx + 1) % FEATURE_COUNT;
  endfunction

  // input side monitor feeding the model on every accepted word
  always @(posedge clk_i) begin
    if (reset_i) begin
      ref_restart();
    end else if (valid_i && ready_o) begin
      bn_relu_pool_ref(data_i);
    end
  end

  // downstream ready pattern
  always @(posedge clk_i) begin
    if (rdy_mode == RDY_RANDOM) begin
      rdy_state = xorshift32(rdy_state);
      ready_i <= rdy_state[9];
    end else begin
      ready_i <= (rdy_mode == RDY_HIGH);
    end
  end

  // compare each output transfer with the head of the queue
  always @(posedge clk_i) begin : compare_outputs
    word_t expected;
    if (!reset_i && valid_o && ready_i) begin
      test_outs++;
      assert (exp_q.size() != 0) else begin
        $display("ERROR: %s gave output %0d while no output was expected", test_name, data_o);
        err_count++;
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        assert (data_o === expected) else begin
          $display("MISMATCH %s: expected %0d actual %0d", test_name, expected, data_o);
          err_count++;
        end
        // all-negative pairs clip to zero
        if (test_id == 3) begin
          assert (data_o === word_t'(0)) else begin
            $display("MISMATCH %s clip: expected 0 actual %0d", test_name, data_o);
            err_count++;
          end
        end
        // saturated pairs leave only the top bound or zero
        if (test_id == 4) begin
          assert (data_o === word_t'(WORD_MAX) || data_o === word_t'(0)) else begin
            $display("MISMATCH %s bound: expected %0d or 0 actual %0d",
                     test_name, WORD_MAX, data_o);
            err_count++;
          end
          if (data_o === word_t'(WORD_MAX)) begin
            max_seen++;
          end
        end
      end
    end
  end

  // present n words and hold each until it transfers
  task automatic send_words(input int n, input int mode, input bit gaps);
    int sent;
    bit pending;
    sent = 0;
    pending = 1'b0;
    while (sent < n) begin
      if (!pending) begin
        stim_state = xorshift32(stim_state);
        if (gaps && (stim_state % 3 == 0)) begin
          valid_i <= 1'b0;
        end else begin
          valid_i <= 1'b1;
          data_i  <= pick_word(mode);
          pending = 1'b1;
        end
      end
      @(posedge clk_i);
      if (pending && ready_o) begin
        sent++;
        pending = 1'b0;
      end
    end
    valid_i <= 1'b0;
  endtask

  task automatic begin_test(input int id, input string name);
    test_id   = id;
    test_name = name;
    err_start = err_count;
    test_outs = 0;
    max_seen  = 0;
  endtask

  // drain the pipeline and report this test
  task automatic end_test(input int exp_outs);
    int errs;
    // last accepted word reaches the queue first
    @(posedge clk_i);
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    // idle cycles catch a repeated word
    repeat (6) @(posedge clk_i);
    assert (test_outs == exp_outs) else begin
      $display("MISMATCH %s output count: expected %0d actual %0d",
               test_name, exp_outs, test_outs);
      err_count++;
    end
    if (test_id == 4) begin
      assert (max_seen > 0) else begin
        $display("ERROR: %s never produced a clipped maximum output", test_name);
        err_count++;
      end
    end
    errs = err_count - err_start;
    total_outs += test_outs;
    tests_run++;
    $display("test %0d %s: %0d outputs checked, %0d errors",
             test_id, test_name, test_outs, errs);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, the pipeline stopped moving",
             WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    stim_state = 32'd45557;
    rdy_state  = ~32'd45557;
    rdy_mode   = RDY_HIGH;
    ref_idx    = 0;
    ref_odd    = 1'b0;
    err_count  = 0;
    total_outs = 0;
    tests_run  = 0;
    begin_test(0, "reset");
    valid_i <= 1'b0;
    data_i  <= '0;
    ready_i <= 1'b1;
    reset_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    // full rate with the index wrapping 8 times
    begin_test(1, "streaming");
    send_words(N_STREAM, MODE_RAND, 1'b0);
    end_test(N_STREAM / 2);

    begin_test(2, "backpressure");
    rdy_mode <= RDY_RANDOM;
    send_words(N_BACKP, MODE_RAND, 1'b1);
    end_test(N_BACKP / 2);

    begin_test(3, "negative");
    rdy_mode <= RDY_HIGH;
    send_words(N_NEG, MODE_NEG, 1'b0);
    end_test(N_NEG / 2);

    begin_test(4, "saturation");
    send_words(N_SAT, MODE_SAT, 1'b0);
    end_test(N_SAT / 2);

    // stall the output and reset with a sample half done
    begin_test(5, "mid_reset");
    rdy_mode <= RDY_LOW;
    @(posedge clk_i);
    send_words(N_PRE, MODE_RAND, 1'b0);
    reset_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    // ready_i still low here so ready_o comes from the reset state alone
    @(negedge clk_i);
    assert (valid_o === 1'b0 && ready_o === 1'b1) else begin
      $display("ERROR: %s left valid_o high or ready_o low after reset", test_name);
      err_count++;
    end
    rdy_mode <= RDY_HIGH;
    @(posedge clk_i);
    send_words(N_POST, MODE_RAND, 1'b0);
    end_test(N_POST / 2);

    $display("summary: %0d tests, %0d outputs checked, %0d errors",
             tests_run, total_outs, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
logic/nn_pkg.sv
logic/coeff_rom.sv
logic/bn_layer.sv
logic/relu_layer.sv
logic/maxpool_layer.sv
logic/nn_top.sv
sim/nn_tb.sv

//--- sim/bn_coeff.hex
// one line per feature, feature 0 first, each line 4 q8.8 words packed
// columns, left to right: mean, inv_std, scale, offset
0100020001800040
ff80010001000000
008004000200ff00
0000018003000080
0200080001000020
fe0001000400ffc0
0040030000800100
0300020002000000
